// File: project.f
hdl/core_pkg.sv
hdl/wb_if.sv
hdl/fetch_unit.sv
hdl/load_store_unit.sv
hdl/wb_arbiter.sv
hdl/wb_ram.sv
hdl/mem_subsystem_top.sv
verification/tb_top.sv

// File: Bender.yml
package:
  name: mem_subsystem

sources:
  - hdl/core_pkg.sv
  - hdl/wb_if.sv
  - hdl/fetch_unit.sv
  - hdl/load_store_unit.sv
  - hdl/wb_arbiter.sv
  - hdl/wb_ram.sv
  - hdl/mem_subsystem_top.sv
  - target: test
    files:
      - verification/tb_top.sv

// File: verification/tb_top.sv
`timescale 1ns/1ps

module tb_top
  import core_pkg::*;
;

  localparam int fill_words = ram_words;
  localparam int word_pairs = 200;
  localparam int byte_groups = 100;
  localparam int mix_ops = 300;
  localparam int seq_fetches = 150;
  localparam int redirect_fetches = 150;
  localparam int mix_fetches = 50;
  localparam int op_budget = 40; // cycles per operation, gaps and stalls included
  localparam int num_ops = fill_words + 2 * word_pairs + 4 * byte_groups + mix_ops
                         + seq_fetches + redirect_fetches + mix_fetches;
  localparam int timeout_cycles = num_ops * op_budget + 8;
  localparam logic [31:0] pc_guard = 32'h0000_03c0; // keep fetch inside words 0..255

  logic clock = 1'b0;
  logic reset;
  logic run;
  logic flush;
  logic [addr_width-1:0] dnpc;
  logic fetch_ready;
  logic fetch_valid;
  logic [addr_width-1:0] fetch_pc;
  logic [data_width-1:0] fetch_inst;
  logic lsu_req_valid;
  logic lsu_req_ready;
  lsu_op_t lsu_op;
  logic [addr_width-1:0] lsu_addr;
  logic [data_width-1:0] lsu_wdata;
  logic lsu_resp_valid;
  logic [data_width-1:0] lsu_rdata;

  integer seed = 32'hbd7d1000;
  integer fetch_seed = 32'hbd7d1000 ^ 32'h0000_ffff; // separate stream for the fetch driver
  logic [31:0] model_mem [ram_words];
  logic [31:0] expected_pc = reset_pc;
  int fetch_mode = 0; // 0 idle, 1 sequential, 2 redirect
  int fetch_count = 0;
  int issued = 0;
  int resp_count = 0;

  mem_subsystem_top dut0 (.*);

  always #4 clock = ~clock;

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
      $display("Simulation finished: FAIL");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  function automatic logic [31:0] word_addr(input int idx, input logic [31:0] noise);
    return {noise[31:12], idx[9:0], noise[1:0]}; // upper and offset bits from noise
  endfunction

  task automatic lsu_access(input lsu_op_t op, input logic [31:0] addr,
                            input logic [31:0] wdata);
    logic [31:0] word;
    logic [7:0] lane;
    logic [31:0] expected;
    @(negedge clock);
    lsu_req_valid = 1'b1;
    lsu_op = op;
    lsu_addr = addr;
    lsu_wdata = wdata;
    while (!lsu_req_ready) @(negedge clock);
    @(negedge clock); // taken on the edge in between
    lsu_req_valid = 1'b0;
    while (lsu_resp_valid !== 1'b1) @(negedge clock);
    word = model_mem[addr[11:2]];
    lane = word[8 * addr[1:0] +: 8];
    case (op)
      op_lw: expected = word;
      op_lb: expected = {{24{lane[7]}}, lane};
      op_lbu: expected = {24'd0, lane};
      default: expected = 32'd0;
    endcase
    check_value(op.name(), expected, lsu_rdata);
    if (op == op_sw) model_mem[addr[11:2]] = wdata;
    if (op == op_sb) model_mem[addr[11:2]][8 * addr[1:0] +: 8] = wdata[7:0];
    issued++;
  endtask

  task automatic wait_fetches(input int n);
    int target;
    target = fetch_count + n;
    while (fetch_count < target) @(negedge clock);
  endtask

  task automatic check_responses();
    @(negedge clock);
    #1;
    check_value("resp_count", issued, resp_count);
  endtask

  always @(negedge clock) begin
    if (!reset && lsu_resp_valid === 1'b1) resp_count++;
  end

  initial begin : fetch_driver
    flush = 1'b0;
    dnpc = '0;
    fetch_ready = 1'b1;
    forever begin
      @(negedge clock);
      if (fetch_mode == 0) begin
        flush = 1'b0;
        fetch_ready = 1'b1;
      end else begin
        fetch_ready = ($random(fetch_seed) & 3) != 0; // ready about 3 cycles in 4
        if (expected_pc >= pc_guard ||
            (fetch_mode == 2 && ($random(fetch_seed) & 7) == 0)) begin
          flush = 1'b1;
          dnpc = $random(fetch_seed) & 32'h0000_03fc;
        end else begin
          flush = 1'b0;
        end
      end
      #1;
      if (flush) begin
        check_value("fetch_valid_masked", 32'd0, fetch_valid);
        expected_pc = dnpc;
      end else if (fetch_valid === 1'b1 && fetch_ready) begin
        check_value("fetch_pc", expected_pc, fetch_pc);
        check_value("fetch_inst", model_mem[expected_pc[11:2]], fetch_inst);
        expected_pc = expected_pc + 32'd4;
        fetch_count++;
      end
    end
  end

  initial begin : watchdog
    repeat (timeout_cycles) @(posedge clock);
    $display("Timeout: the run did not complete within %0d cycles", timeout_cycles);
    $display("Simulation finished: FAIL");
    $fatal(1, "watchdog expired");
  end

  initial begin : main
    int idx;
    logic [31:0] addr;
    reset = 1'b1;
    run = 1'b0;
    lsu_req_valid = 1'b0;
    lsu_op = op_lw;
    lsu_addr = '0;
    lsu_wdata = '0;
    repeat (8) begin
      @(negedge clock);
      check_value("reset_fetch_valid", 32'd0, fetch_valid);
      check_value("reset_resp_valid", 32'd0, lsu_resp_valid);
      check_value("reset_req_ready", 32'd1, lsu_req_ready);
    end
    reset = 1'b0;
    repeat (2) begin
      @(negedge clock);
      check_value("post_reset_fetch_valid", 32'd0, fetch_valid);
      check_value("post_reset_resp_valid", 32'd0, lsu_resp_valid);
      check_value("post_reset_req_ready", 32'd1, lsu_req_ready);
    end

    for (int i = 0; i < fill_words; i++) begin
      lsu_access(op_sw, word_addr(i, $random(seed)), $random(seed));
    end
    for (int i = 0; i < word_pairs; i++) begin
      idx = ($random(seed) & 32'h7fff_ffff) % ram_words;
      addr = word_addr(idx, $random(seed));
      lsu_access(op_sw, addr, $random(seed));
      lsu_access(op_lw, addr, $random(seed));
    end
    for (int i = 0; i < byte_groups; i++) begin
      idx = ($random(seed) & 32'h7fff_ffff) % ram_words;
      addr = word_addr(idx, $random(seed));
      lsu_access(op_sb, addr, $random(seed));
      lsu_access(op_lw, addr, $random(seed));
      lsu_access(op_lb, addr, $random(seed));
      lsu_access(op_lbu, addr, $random(seed));
    end
    check_responses();

    @(negedge clock);
    run = 1'b1;
    @(posedge clock);
    fetch_mode = 1;
    wait_fetches(seq_fetches);
    @(posedge clock);
    fetch_mode = 2;
    wait_fetches(redirect_fetches);

    // lsu stays above the fetch region while fetch runs
    for (int i = 0; i < mix_ops; i++) begin
      repeat ($random(seed) & 7) @(negedge clock);
      idx = 256 + ($random(seed) & 32'h7fff_ffff) % (ram_words - 256);
      lsu_access(lsu_op_t'(($random(seed) & 32'h7fff_ffff) % 5),
                 word_addr(idx, $random(seed)), $random(seed));
    end
    wait_fetches(mix_fetches);
    check_responses();

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// File: hdl/mem_subsystem_top.sv
`timescale 1ns/1ps

module mem_subsystem_top
  import core_pkg::*;
(
  input logic clock,
  input logic reset,
  input logic run,
  input logic flush,
  input logic [addr_width-1:0] dnpc,
  input logic fetch_ready,
  output logic fetch_valid,
  output logic [addr_width-1:0] fetch_pc,
  output logic [data_width-1:0] fetch_inst,
  input logic lsu_req_valid,
  output logic lsu_req_ready,
  input lsu_op_t lsu_op,
  input logic [addr_width-1:0] lsu_addr,
  input logic [data_width-1:0] lsu_wdata,
  output logic lsu_resp_valid,
  output logic [data_width-1:0] lsu_rdata
);

  wb_if fetch_bus ();
  wb_if lsu_bus ();
  wb_if ram_bus ();

  fetch_unit u_fetch (
    .clock (clock),
    .reset (reset),
    .run   (run),
    .flush (flush),
    .dnpc  (dnpc),
    .ready (fetch_ready),
    .valid (fetch_valid),
    .pc    (fetch_pc),
    .inst  (fetch_inst),
    .bus   (fetch_bus.master)
  );

  load_store_unit u_lsu (
    .clock      (clock),
    .reset      (reset),
    .req_valid  (lsu_req_valid),
    .req_ready  (lsu_req_ready),
    .op         (lsu_op),
    .addr       (lsu_addr),
    .wdata      (lsu_wdata),
    .resp_valid (lsu_resp_valid),
    .rdata      (lsu_rdata),
    .bus        (lsu_bus.master)
  );

  wb_arbiter u_arb (
    .clock (clock),
    .reset (reset),
    .m0    (fetch_bus.slave), // fetch side
    .m1    (lsu_bus.slave),
    .s     (ram_bus.master)
  );

  wb_ram u_ram (
    .clock (clock),
    .reset (reset),
    .bus   (ram_bus.slave)
  );

endmodule

// File: hdl/wb_ram.sv
`timescale 1ns/1ps

module wb_ram
  import core_pkg::*;
(
  input logic clock,
  input logic reset,
  wb_if.slave bus
);

  logic [data_width-1:0] mem [ram_words];
  logic [$clog2(ram_words)-1:0] word_idx;
  logic req;
  logic ack_q;
  logic [data_width-1:0] rdata_q;

  assign word_idx = bus.adr[$clog2(ram_words)+1:2]; // upper bits ignored
  assign req = bus.cyc & bus.stb;

  assign bus.ack = ack_q;
  assign bus.dat_r = rdata_q;

  // one ack per request, never back to back
  always_ff @(posedge clock) begin
    if (reset) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req & ~ack_q;
    end
  end

  always_ff @(posedge clock) begin
    if (req & ~ack_q) begin
      rdata_q <= mem[word_idx]; // ready for the ack cycle
    end
    if (req & ack_q & bus.we) begin
      for (int i = 0; i < sel_width; i++) begin
        if (bus.sel[i]) begin
          mem[word_idx][8*i +: 8] <= bus.dat_w[8*i +: 8];
        end
      end
    end
  end

  assert property (@(posedge clock) disable iff (reset) bus.ack |-> bus.cyc)
    else $error("wb_ram: ack without cyc");

endmodule

// File: hdl/wb_arbiter.sv
`timescale 1ns/1ps

module wb_arbiter
  import core_pkg::*;
(
  input logic clock,
  input logic reset,
  wb_if.slave m0,
  wb_if.slave m1,
  wb_if.master s
);

  arb_state_t state;
  arb_state_t state_next;
  arb_state_t grant;
  logic last_m1; // m1 was served last
  logic req0;
  logic req1;

  assign req0 = m0.cyc & m0.stb;
  assign req1 = m1.cyc & m1.stb;

  always_comb begin
    state_next = state;
    case (state)
      arb_idle: begin
        if (req0 & (~req1 | last_m1)) begin
          state_next = arb_m0;
        end else if (req1) begin
          state_next = arb_m1;
        end
      end
      arb_m0, arb_m1: begin
        if (s.ack) begin
          state_next = arb_idle;
        end
      end
      default: begin
        state_next = arb_idle;
      end
    endcase
  end

  // idle decision is forwarded at once, no added cycle
  assign grant = (state == arb_idle) ? state_next : state;

  always_comb begin
    s.cyc = 1'b0;
    s.stb = 1'b0;
    s.we = m0.we;
    s.adr = m0.adr;
    s.dat_w = m0.dat_w;
    s.sel = m0.sel;
    if (grant == arb_m0) begin
      s.cyc = m0.cyc;
      s.stb = m0.stb;
    end else if (grant == arb_m1) begin
      s.cyc = m1.cyc;
      s.stb = m1.stb;
      s.we = m1.we;
      s.adr = m1.adr;
      s.dat_w = m1.dat_w;
      s.sel = m1.sel;
    end
  end

  assign m0.ack = s.ack & (state == arb_m0);
  assign m1.ack = s.ack & (state == arb_m1);
  assign m0.dat_r = s.dat_r;
  assign m1.dat_r = s.dat_r;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= arb_idle;
      last_m1 <= 1'b1; // fetch wins the first tie
    end else begin
      state <= state_next;
      if (s.ack & (state != arb_idle)) begin
        last_m1 <= (state == arb_m1);
      end
    end
  end

  assert property (@(posedge clock) disable iff (reset) s.ack |-> (m0.ack || m1.ack))
    else $error("wb_arbiter: ack not routed to any master");

endmodule

// File: hdl/load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit
  import core_pkg::*;
(
  input logic clock,
  input logic reset,
  input logic req_valid,
  output logic req_ready,
  input lsu_op_t op,
  input logic [addr_width-1:0] addr,
  input logic [data_width-1:0] wdata,
  output logic resp_valid,
  output logic [data_width-1:0] rdata,
  wb_if.master bus
);

  lsu_state_t state;
  lsu_op_t op_q;
  logic [addr_width-1:0] addr_q;
  logic [data_width-1:0] wdata_q;
  logic [data_width-1:0] rdata_q;
  logic is_store;
  logic is_byte;
  logic [sel_width-1:0] byte_sel;
  logic [7:0] lane_byte;
  logic [data_width-1:0] load_value;

  assign is_store = (op_q == op_sw) | (op_q == op_sb);
  assign is_byte = (op_q == op_lb) | (op_q == op_lbu) | (op_q == op_sb);

  assign req_ready = (state == lsu_idle);
  assign resp_valid = (state == lsu_done); // single cycle pulse
  assign rdata = rdata_q;

  assign bus.cyc = (state == lsu_bus);
  assign bus.stb = (state == lsu_bus);
  assign bus.we = is_store;
  assign bus.adr = is_byte ? addr_q : {addr_q[addr_width-1:2], 2'b00};
  assign bus.sel = is_byte ? byte_sel : '1;
  assign bus.dat_w = (op_q == op_sb) ? {sel_width{wdata_q[7:0]}} : wdata_q;

  always_comb begin
    case (addr_q[1:0])
      2'd0: byte_sel = 4'b0001;
      2'd1: byte_sel = 4'b0010;
      2'd2: byte_sel = 4'b0100;
      default: byte_sel = 4'b1000;
    endcase
  end

  assign lane_byte = bus.dat_r[8*addr_q[1:0] +: 8];

  always_comb begin
    case (op_q)
      op_lw: load_value = bus.dat_r;
      op_lb: load_value = {{(data_width-8){lane_byte[7]}}, lane_byte};
      op_lbu: load_value = {{(data_width-8){1'b0}}, lane_byte};
      default: load_value = '0; // stores
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= lsu_idle;
    end else begin
      case (state)
        lsu_idle: begin
          if (req_valid) begin
            state <= lsu_bus;
          end
        end
        lsu_bus: begin
          if (bus.ack) begin
            state <= lsu_done;
          end
        end
        default: begin
          state <= lsu_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (req_valid & req_ready) begin
      op_q <= op;
      addr_q <= addr;
      wdata_q <= wdata;
    end
    if ((state == lsu_bus) & bus.ack) begin
      rdata_q <= load_value;
    end
  end

endmodule

// File: hdl/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit
  import core_pkg::*;
(
  input logic clock,
  input logic reset,
  input logic run,
  input logic flush,
  input logic [addr_width-1:0] dnpc,
  input logic ready,
  output logic valid,
  output logic [addr_width-1:0] pc,
  output logic [data_width-1:0] inst,
  wb_if.master bus
);

  fetch_state_t state;
  fetch_state_t state_next;
  logic [addr_width-1:0] pc_next;
  logic [data_width-1:0] inst_next;
  logic stale;
  logic stale_next;
  logic open_q;
  logic [addr_width-1:0] adr_q;
  logic stb;

  // once opened the cycle stays up until ack, even if run drops
  assign stb = (state == fetch_req) & (run | open_q);

  assign bus.cyc = stb;
  assign bus.stb = stb;
  assign bus.we = 1'b0;
  assign bus.adr = open_q ? adr_q : pc; // frozen while the cycle is open
  assign bus.dat_w = '0;
  assign bus.sel = '1; // whole word

  assign valid = (state == fetch_hold) & ~flush;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= fetch_req;
      pc <= reset_pc;
      inst <= nop_inst;
      stale <= 1'b0;
      open_q <= 1'b0;
    end else begin
      state <= state_next;
      pc <= pc_next;
      inst <= inst_next;
      stale <= stale_next;
      open_q <= stb & ~bus.ack;
    end
  end

  always_ff @(posedge clock) begin
    if (stb & ~open_q) begin
      adr_q <= pc; // first cycle of stb
    end
  end

  always_comb begin
    state_next = state;
    pc_next = pc;
    inst_next = inst;
    stale_next = stale;
    case (state)
      fetch_req: begin
        if (flush) begin
          pc_next = dnpc;
          if (stb) begin
            stale_next = 1'b1; // read already on the bus, drop it later
          end
        end
        if (bus.ack) begin
          state_next = fetch_resp;
          if (~stale_next) begin
            inst_next = bus.dat_r;
          end
        end
      end
      fetch_resp: begin
        stale_next = 1'b0;
        if (flush) begin
          state_next = fetch_req;
          pc_next = dnpc;
        end else if (stale) begin
          state_next = fetch_req; // refetch from the redirect target
        end else begin
          state_next = fetch_hold;
        end
      end
      fetch_hold: begin
        if (flush) begin
          state_next = fetch_req;
          pc_next = dnpc;
        end else if (ready & valid) begin
          state_next = fetch_req;
          pc_next = pc + 32'd4;
        end
      end
      default: begin
        state_next = fetch_req;
      end
    endcase
  end

  // request address must not move under an open cycle, flush or not
  assert property (@(posedge clock) disable iff (reset)
    (bus.stb && !bus.ack) |=> $stable(bus.adr))
    else $error("fetch_unit: adr changed during open cycle");

endmodule

// File: hdl/wb_if.sv
`timescale 1ns/1ps

interface wb_if;

  logic cyc;
  logic stb;
  logic we;
  logic [core_pkg::addr_width-1:0] adr;
  logic [core_pkg::data_width-1:0] dat_w;
  logic [core_pkg::sel_width-1:0] sel;
  logic [core_pkg::data_width-1:0] dat_r;
  logic ack;

  modport master (
    output cyc, stb, we, adr, dat_w, sel,
    input dat_r, ack
  );

  modport slave (
    input cyc, stb, we, adr, dat_w, sel,
    output dat_r, ack
  );

endinterface

// File: hdl/core_pkg.sv
package core_pkg;

  localparam int addr_width = 32;
  localparam int data_width = 32;
  localparam int sel_width = 4;

  localparam logic [addr_width-1:0] reset_pc = 32'h0000_0000;
  localparam int ram_words = 1024; // indexed by adr[11:2]
  localparam logic [data_width-1:0] nop_inst = 32'h0000_0013; // addi x0, x0, 0

  typedef enum logic [1:0] {
    fetch_req,  // cycle pending or open on the bus
    fetch_resp, // ack seen, decide keep or drop
    fetch_hold  // instruction waits for downstream
  } fetch_state_t;

  typedef enum logic [2:0] {
    op_lw,
    op_lb,
    op_lbu,
    op_sw,
    op_sb
  } lsu_op_t;

  typedef enum logic [1:0] {
    lsu_idle,
    lsu_bus,
    lsu_done
  } lsu_state_t;

  typedef enum logic [1:0] {
    arb_idle,
    arb_m0,
    arb_m1
  } arb_state_t;

endpackage
